/* design/mips_decode_pkg.sv */
`default_nettype none

package mips_decode_pkg;

    typedef enum logic [7:0] {
        // SPECIAL function codes
        op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
        op_jr, op_jalr, op_syscall, op_break,
        op_mfhi, op_mthi, op_mflo, op_mtlo,
        op_mult, op_div,
        op_add, op_sub, op_and, op_or, op_xor, op_nor, op_slt,
        // branches, memory and jumps
        op_bltz, op_bgez, op_bltzal, op_bgezal,
        op_beq, op_bne, op_blez, op_bgtz,
        op_lu, op_lb, op_lh, op_lw, op_lwl, op_lwr,
        op_sb, op_sh, op_sw, op_swl, op_swr,
        op_cache, op_pref, op_j, op_jal,
        // coprocessor 0
        op_mfc0, op_mtc0, op_eret, op_wait,
        op_tlbr, op_tlbwi, op_tlbwr, op_tlbp,
        op_invalid
    } op_e;

    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j_fmt;
    } inst_u;

    // 71 bits in total
    typedef struct packed {
        op_e         op;
        logic [4:0]  reg_s;
        logic [4:0]  reg_t;
        logic [4:0]  reg_d;    // R-type only
        logic [4:0]  shamt;    // R-type only
        logic [15:0] immediate;
        logic [25:0] target;   // J-type only
        logic        flag_unsigned;
    } decoded_t;

endpackage

`default_nettype wire

/* design/inst_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_receiver import mips_decode_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_req,
    input  inst_u in_word,
    input  logic  take,
    output logic  in_ack,
    output logic  word_valid,
    output inst_u word
);

    typedef enum logic {
        rx_idle,
        rx_ack
    } rx_state_e;

    rx_state_e state;
    logic      capture;

    // new request meets an empty slot while ack is low
    assign capture = (state == rx_idle) && in_req && !word_valid;
    assign in_ack  = (state == rx_ack);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rx_idle;
            word_valid <= 1'b0;
        end else begin
            case (state)
                rx_idle: if (capture) state <= rx_ack;
                rx_ack:  if (!in_req) state <= rx_idle; // return to zero
                default: state <= rx_idle;
            endcase
            if (capture) begin
                word_valid <= 1'b1;
            end else if (take) begin
                word_valid <= 1'b0; // sender has it now
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            word <= in_word;
        end
    end

endmodule

`default_nettype wire

/* design/id_i.sv */
`timescale 1ns/1ps
`default_nettype none

module id_i import mips_decode_pkg::*; #(
    parameter bit with_tlb   = 1'b1,
    parameter bit with_cache = 1'b1
) (
    input  inst_u       inst,
    output op_e         op,
    output logic [4:0]  reg_s,
    output logic [4:0]  reg_t,
    output logic [15:0] immediate,
    output logic        flag_unsigned
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       cache_bad;

    assign opcode    = inst.i_fmt.opcode;
    assign funct     = inst.r_fmt.funct; // only meaningful for COP0
    assign reg_s     = inst.i_fmt.rs;
    assign reg_t     = inst.i_fmt.rt;
    assign immediate = inst.i_fmt.imm;

    assign cache_bad = !with_cache || (reg_t == 5'b11000) || (&reg_t[2:1]);

    // addiu, sltiu, lbu, lhu
    assign flag_unsigned = (opcode == 6'h09) || (opcode == 6'h0b) ||
                           (opcode == 6'h24) || (opcode == 6'h25);

    always_comb begin
        op = op_invalid;
        case (opcode)
            6'h01: begin // REGIMM
                case (reg_t)
                    5'h00:   op = op_bltz;
                    5'h01:   op = op_bgez;
                    5'h10:   op = op_bltzal;
                    5'h11:   op = op_bgezal;
                    default: op = op_invalid;
                endcase
            end
            6'h04:         op = op_beq;
            6'h05:         op = op_bne;
            6'h06:         op = (reg_t == 5'h0) ? op_blez : op_invalid;
            6'h07:         op = (reg_t == 5'h0) ? op_bgtz : op_invalid;
            6'h08, 6'h09:  op = op_add;
            6'h0a, 6'h0b:  op = op_slt;
            6'h0c:         op = op_and;
            6'h0d:         op = op_or;
            6'h0e:         op = op_xor;
            6'h0f:         op = (reg_s == 5'h0) ? op_lu : op_invalid;
            6'h10: begin
                if (reg_s == 5'h0) begin
                    op = op_mfc0;
                end else if (reg_s == 5'h4) begin
                    op = op_mtc0;
                end else if (reg_s[4]) begin // CO bit
                    case (funct)
                        6'h18:   op = op_eret;
                        6'h20:   op = op_wait;
                        6'h01:   op = with_tlb ? op_tlbr : op_invalid;
                        6'h02:   op = with_tlb ? op_tlbwi : op_invalid;
                        6'h06:   op = with_tlb ? op_tlbwr : op_invalid;
                        6'h08:   op = with_tlb ? op_tlbp : op_invalid;
                        default: op = op_invalid;
                    endcase
                end
            end
            6'h20, 6'h24:  op = op_lb;
            6'h21, 6'h25:  op = op_lh;
            6'h22:         op = op_lwl;
            6'h23:         op = op_lw;
            6'h26:         op = op_lwr;
            6'h28:         op = op_sb;
            6'h29:         op = op_sh;
            6'h2a:         op = op_swl;
            6'h2b:         op = op_sw;
            6'h2e:         op = op_swr;
            6'h2f:         op = cache_bad ? op_invalid : op_cache;
            6'h33:         op = op_pref;
            default:       op = op_invalid;
        endcase
    end

endmodule

`default_nettype wire

/* design/id_r.sv */
`timescale 1ns/1ps
`default_nettype none

module id_r import mips_decode_pkg::*; (
    input  inst_u inst,
    output op_e   op,
    output logic  flag_unsigned
);

    logic [5:0] funct;

    assign funct = inst.r_fmt.funct;

    // addu, subu, sltu, multu, divu
    assign flag_unsigned = (funct == 6'h21) || (funct == 6'h23) ||
                           (funct == 6'h2b) || (funct == 6'h19) ||
                           (funct == 6'h1b);

    always_comb begin
        case (funct)
            6'h00:        op = op_sll;
            6'h02:        op = op_srl;
            6'h03:        op = op_sra;
            6'h04:        op = op_sllv;
            6'h06:        op = op_srlv;
            6'h07:        op = op_srav;
            6'h08:        op = op_jr;
            6'h09:        op = op_jalr;
            6'h0c:        op = op_syscall;
            6'h0d:        op = op_break;
            6'h10:        op = op_mfhi;
            6'h11:        op = op_mthi;
            6'h12:        op = op_mflo;
            6'h13:        op = op_mtlo;
            6'h18, 6'h19: op = op_mult;
            6'h1a, 6'h1b: op = op_div;
            6'h20, 6'h21: op = op_add;
            6'h22, 6'h23: op = op_sub;
            6'h24:        op = op_and;
            6'h25:        op = op_or;
            6'h26:        op = op_xor;
            6'h27:        op = op_nor;
            6'h2a, 6'h2b: op = op_slt;
            default:      op = op_invalid;
        endcase
    end

endmodule

`default_nettype wire

/* design/decode_core.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_core import mips_decode_pkg::*; #(
    parameter bit with_tlb   = 1'b1,
    parameter bit with_cache = 1'b1
) (
    input  inst_u    word,
    output decoded_t dec
);

    op_e         i_op;
    op_e         r_op;
    logic [4:0]  i_reg_s;
    logic [4:0]  i_reg_t;
    logic [15:0] i_imm;
    logic        i_unsigned;
    logic        r_unsigned;
    logic        is_r;
    logic        is_j;

    id_i #(
        .with_tlb   (with_tlb),
        .with_cache (with_cache)
    ) i_id_i (
        .inst          (word),
        .op            (i_op),
        .reg_s         (i_reg_s),
        .reg_t         (i_reg_t),
        .immediate     (i_imm),
        .flag_unsigned (i_unsigned)
    );

    id_r i_id_r (
        .inst          (word),
        .op            (r_op),
        .flag_unsigned (r_unsigned)
    );

    assign is_r = (word.r_fmt.opcode == 6'h00);
    assign is_j = (word.j_fmt.opcode == 6'h02) || (word.j_fmt.opcode == 6'h03);

    always_comb begin
        dec.reg_s     = i_reg_s;
        dec.reg_t     = i_reg_t;
        dec.immediate = i_imm;
        dec.reg_d     = is_r ? word.r_fmt.rd : 5'd0;
        dec.shamt     = is_r ? word.r_fmt.shamt : 5'd0;
        dec.target    = is_j ? word.j_fmt.target : 26'd0;
        if (is_r) begin
            dec.op            = r_op;
            dec.flag_unsigned = r_unsigned;
        end else if (is_j) begin
            dec.op            = word.j_fmt.opcode[0] ? op_jal : op_j; // 3 is jal
            dec.flag_unsigned = 1'b0;
        end else begin
            dec.op            = i_op;
            dec.flag_unsigned = i_unsigned;
        end
    end

endmodule

`default_nettype wire

/* design/decode_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_sender import mips_decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     word_valid,
    input  decoded_t dec,
    input  logic     out_ack,
    output logic     take,
    output logic     out_req,
    output decoded_t out_dec
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_req,
        tx_drain
    } tx_state_e;

    tx_state_e state;

    assign take    = word_valid && (state == tx_idle);
    assign out_req = (state == tx_req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tx_idle;
        end else begin
            case (state)
                tx_idle: begin
                    if (take) state <= tx_req;
                end
                tx_req: begin
                    if (out_ack) state <= tx_drain; // drop req next cycle
                end
                tx_drain: begin
                    // wait for the slave to release ack
                    if (!out_ack) state <= tx_idle;
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_dec <= dec;
        end
    end

endmodule

`default_nettype wire

/* design/inst_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode_top import mips_decode_pkg::*; #(
    parameter bit with_tlb   = 1'b1,
    parameter bit with_cache = 1'b1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_req,
    input  inst_u    in_word,
    output logic     in_ack,
    output logic     out_req,
    output decoded_t out_dec,
    input  logic     out_ack
);

    logic     word_valid;
    logic     take;
    inst_u    word;
    decoded_t dec;

    inst_receiver i_receiver (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_word    (in_word),
        .take       (take),
        .in_ack     (in_ack),
        .word_valid (word_valid),
        .word       (word)
    );

    decode_core #(
        .with_tlb   (with_tlb),
        .with_cache (with_cache)
    ) i_core (
        .word (word),
        .dec  (dec)
    );

    // output slot, second item in flight
    decode_sender i_sender (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .dec        (dec),
        .out_ack    (out_ack),
        .take       (take),
        .out_req    (out_req),
        .out_dec    (out_dec)
    );

endmodule

`default_nettype wire

/* dv/inst_decode_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode_assert import mips_decode_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     in_req,
    input logic     in_ack,
    input logic     out_req,
    input logic     out_ack,
    input decoded_t out_dec
);

    int fail_count = 0;

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else begin
            $error("out_req dropped before out_ack");
            fail_count++;
        end

    dec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req |=> !out_req || $stable(out_dec))
        else begin
            $error("out_dec changed while out_req high");
            fail_count++;
        end

    // slave side only answers a live request
    ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else begin
            $error("in_ack rose without in_req");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !in_req && !in_ack && !out_req && !out_ack)
        else begin
            $error("handshake active during reset");
            fail_count++;
        end

endmodule

bind inst_decode_top inst_decode_assert i_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_dec (out_dec)
);

`default_nettype wire

/* dv/tb_inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_inst_decode import mips_decode_pkg::*; ();

    localparam int max_wait      = 50;
    localparam bit tlb_present   = 1'b1;
    localparam bit cache_present = 1'b1;

    logic     clk;
    logic     rst_n;
    logic     in_req;
    inst_u    in_word;
    logic     in_ack;
    logic     out_req;
    decoded_t out_dec;
    logic     out_ack;

    int       checks;
    int       errors;
    bit       timed_out;
    decoded_t exp_q[$];

    inst_decode_top #(
        .with_tlb   (tlb_present),
        .with_cache (cache_present)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_word (in_word),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_dec (out_dec),
        .out_ack (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic inst_u mk_i(input logic [5:0] opc, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic inst_u mk_r(input logic [5:0] opc, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [4:0] rd,
                                   input logic [4:0] sh, input logic [5:0] fn);
        return {opc, rs, rt, rd, sh, fn};
    endfunction

    function automatic inst_u mk_j(input logic [5:0] opc, input logic [25:0] tgt);
        return {opc, tgt};
    endfunction

    // SPECIAL function field
    function automatic op_e ref_special(input logic [5:0] fn);
        case (fn)
            6'h00: return op_sll;
            6'h02: return op_srl;
            6'h03: return op_sra;
            6'h04: return op_sllv;
            6'h06: return op_srlv;
            6'h07: return op_srav;
            6'h08: return op_jr;
            6'h09: return op_jalr;
            6'h0c: return op_syscall;
            6'h0d: return op_break;
            6'h10: return op_mfhi;
            6'h11: return op_mthi;
            6'h12: return op_mflo;
            6'h13: return op_mtlo;
            6'h18, 6'h19: return op_mult;
            6'h1a, 6'h1b: return op_div;
            6'h20, 6'h21: return op_add;
            6'h22, 6'h23: return op_sub;
            6'h24: return op_and;
            6'h25: return op_or;
            6'h26: return op_xor;
            6'h27: return op_nor;
            6'h2a, 6'h2b: return op_slt;
            default: return op_invalid;
        endcase
    endfunction

    function automatic op_e ref_cop0(input inst_u w);
        if (w.i_fmt.rs == 5'd0) return op_mfc0;
        if (w.i_fmt.rs == 5'd4) return op_mtc0;
        if (w.i_fmt.rs[4]) begin // CO set, funct picks the op
            case (w.r_fmt.funct)
                6'h18: return op_eret;
                6'h20: return op_wait;
                6'h01: if (tlb_present) return op_tlbr;
                6'h02: if (tlb_present) return op_tlbwi;
                6'h06: if (tlb_present) return op_tlbwr;
                6'h08: if (tlb_present) return op_tlbp;
                default: return op_invalid;
            endcase
        end
        return op_invalid;
    endfunction

    function automatic op_e ref_imm(input inst_u w);
        logic [4:0] rs;
        logic [4:0] rt;
        rs = w.i_fmt.rs;
        rt = w.i_fmt.rt;
        case (w.i_fmt.opcode)
            6'h01: begin
                if (rt == 5'h00) return op_bltz;
                if (rt == 5'h01) return op_bgez;
                if (rt == 5'h10) return op_bltzal;
                if (rt == 5'h11) return op_bgezal;
            end
            6'h04: return op_beq;
            6'h05: return op_bne;
            6'h06: if (rt == 5'h00) return op_blez;
            6'h07: if (rt == 5'h00) return op_bgtz;
            6'h08, 6'h09: return op_add;
            6'h0a, 6'h0b: return op_slt;
            6'h0c: return op_and;
            6'h0d: return op_or;
            6'h0e: return op_xor;
            6'h0f: if (rs == 5'h00) return op_lu;
            6'h10: return ref_cop0(w);
            6'h20, 6'h24: return op_lb;
            6'h21, 6'h25: return op_lh;
            6'h22: return op_lwl;
            6'h23: return op_lw;
            6'h26: return op_lwr;
            6'h28: return op_sb;
            6'h29: return op_sh;
            6'h2a: return op_swl;
            6'h2b: return op_sw;
            6'h2e: return op_swr;
            6'h2f: if (cache_present && rt != 5'b11000 && !(rt[2] && rt[1])) return op_cache;
            6'h33: return op_pref;
            default: return op_invalid;
        endcase
        return op_invalid;
    endfunction

    function automatic decoded_t predict(input inst_u w);
        decoded_t   d;
        logic [5:0] opc;
        opc         = w.i_fmt.opcode;
        d           = '0;
        d.reg_s     = w.i_fmt.rs;
        d.reg_t     = w.i_fmt.rt;
        d.immediate = w.i_fmt.imm;
        if (opc == 6'h00) begin
            d.op            = ref_special(w.r_fmt.funct);
            d.flag_unsigned = w.r_fmt.funct inside {6'h19, 6'h1b, 6'h21, 6'h23, 6'h2b};
            d.reg_d         = w.r_fmt.rd;
            d.shamt         = w.r_fmt.shamt;
        end else if (opc == 6'h02 || opc == 6'h03) begin
            d.op     = (opc == 6'h02) ? op_j : op_jal;
            d.target = w.j_fmt.target;
        end else begin
            d.op            = ref_imm(w);
            d.flag_unsigned = opc inside {6'h09, 6'h0b, 6'h24, 6'h25};
        end
        return d;
    endfunction

    task automatic report_timeout(input string what);
        if (!timed_out) begin
            $display("timeout at %0t: %s did not change within %0d cycles",
                     $time, what, max_wait);
        end
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        if (timed_out) return;
        do begin
            @(negedge clk);
            n++;
        end while (in_ack !== level && n < max_wait);
        if (in_ack !== level) report_timeout("in_ack");
    endtask

    task automatic wait_out_req(input logic level);
        int n;
        n = 0;
        if (timed_out) return;
        do begin
            @(negedge clk);
            n++;
        end while (out_req !== level && n < max_wait);
        if (out_req !== level) report_timeout("out_req");
    endtask

    task automatic raise_req(input inst_u w);
        @(negedge clk);
        in_word = w;
        in_req  = 1'b1;
    endtask

    // rest of the four-phase cycle once req is up
    task automatic finish_send();
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic send_word(input inst_u w);
        raise_req(w);
        finish_send();
    endtask

    task automatic recv_dec(output decoded_t got, input int delay);
        wait_out_req(1'b1);
        got = out_dec;
        repeat (delay) @(negedge clk);
        out_ack = 1'b1;
        wait_out_req(1'b0);
        out_ack = 1'b0;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp) else begin
            $display("error %0t %s: expected %b, got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_dec(input decoded_t got, input decoded_t exp);
        checks++;
        assert (got === exp) else begin
            $display("error %0t out_dec: expected %h (%s), got %h (%s)",
                     $time, exp, exp.op.name(), got, got.op.name());
            errors++;
        end
    endtask

    task automatic check_word(input inst_u w);
        decoded_t got;
        send_word(w);
        recv_dec(got, 0);
        check_dec(got, predict(w));
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %-12s %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic test_idle();
        int c0 = checks;
        int e0 = errors;
        repeat (6) begin
            @(negedge clk);
            check_bit("in_ack", 1'b0, in_ack);
            check_bit("out_req", 1'b0, out_req);
        end
        report_test("idle", c0, e0);
    endtask

    task automatic test_itype();
        int c0 = checks;
        int e0 = errors;
        logic [5:0] opcodes [$] = '{6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a,
                                    6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21,
                                    6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h28, 6'h29,
                                    6'h2a, 6'h2b, 6'h2e, 6'h33, 6'h3f};
        logic [4:0] regimm_rt [$] = '{5'h00, 5'h01, 5'h10, 5'h11, 5'h02};
        logic [4:0] cache_rt [$]  = '{5'h00, 5'h02, 5'h18, 5'h06, 5'h1e};
        // second pass makes blez, bgtz and lui invalid
        foreach (opcodes[k]) begin
            check_word(mk_i(opcodes[k], 5'd0, 5'd0, 16'($urandom)));
            check_word(mk_i(opcodes[k], 5'd7, 5'd3, 16'($urandom)));
        end
        foreach (regimm_rt[k]) begin
            check_word(mk_i(6'h01, 5'd2, regimm_rt[k], 16'($urandom)));
        end
        foreach (cache_rt[k]) begin
            check_word(mk_i(6'h2f, 5'd4, cache_rt[k], 16'($urandom)));
        end
        report_test("itype", c0, e0);
    endtask

    task automatic test_rjtype();
        int c0 = checks;
        int e0 = errors;
        for (int fn = 0; fn < 64; fn++) begin
            check_word(mk_r(6'h00, 5'($urandom), 5'($urandom), 5'($urandom),
                            5'($urandom), 6'(fn)));
        end
        check_word(mk_j(6'h02, 26'($urandom)));
        check_word(mk_j(6'h03, 26'($urandom)));
        report_test("rjtype", c0, e0);
    endtask

    task automatic test_cop0();
        int c0 = checks;
        int e0 = errors;
        logic [5:0] co_funct [$] = '{6'h18, 6'h20, 6'h01, 6'h02, 6'h06, 6'h08, 6'h03};
        check_word(mk_r(6'h10, 5'h00, 5'd9, 5'd12, 5'd0, 6'h00));
        check_word(mk_r(6'h10, 5'h04, 5'd9, 5'd12, 5'd0, 6'h00));
        check_word(mk_r(6'h10, 5'h02, 5'd9, 5'd12, 5'd0, 6'h00)); // bad rs
        foreach (co_funct[k]) begin
            check_word(mk_r(6'h10, 5'h10, 5'd0, 5'd0, 5'd0, co_funct[k]));
        end
        report_test("cop0", c0, e0);
    endtask

    task automatic test_backpressure();
        int       c0 = checks;
        int       e0 = errors;
        inst_u    w [3];
        decoded_t got [3];
        w[0] = mk_i(6'h23, 5'd1, 5'd2, 16'h1234);
        w[1] = mk_r(6'h00, 5'd3, 5'd4, 5'd5, 5'd0, 6'h21);
        w[2] = mk_j(6'h03, 26'h2abcdef);
        send_word(w[0]);
        send_word(w[1]);
        raise_req(w[2]);
        // both slots full, third word must wait
        repeat (10) begin
            @(negedge clk);
            check_bit("in_ack", 1'b0, in_ack);
        end
        fork
            finish_send();
            begin
                for (int k = 0; k < 3; k++) begin
                    recv_dec(got[k], 0);
                end
            end
        join
        for (int k = 0; k < 3; k++) begin
            check_dec(got[k], predict(w[k]));
        end
        report_test("backpressure", c0, e0);
    endtask

    task automatic test_random();
        int c0 = checks;
        int e0 = errors;
        fork
            begin
                inst_u w;
                for (int n = 0; n < 200; n++) begin
                    w = $urandom();
                    if ($urandom_range(0, 3) == 0) w.r_fmt.opcode = 6'h00;
                    exp_q.push_back(predict(w));
                    send_word(w);
                end
            end
            begin
                decoded_t got;
                for (int n = 0; n < 200; n++) begin
                    recv_dec(got, int'($urandom_range(0, 4)));
                    check_dec(got, exp_q.pop_front());
                end
            end
        join
        report_test("random", c0, e0);
    endtask

    initial begin
        void'($urandom(32'h5d4c_ff8c));
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_word   = '0;
        out_ack   = 1'b0;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_idle();
        test_itype();
        test_rjtype();
        test_cop0();
        test_backpressure();
        test_random();
        errors += i_dut.i_assert.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/mips_decode_pkg.sv
design/inst_receiver.sv
design/id_i.sv
design/id_r.sv
design/decode_core.sv
design/decode_sender.sv
design/inst_decode_top.sv
dv/inst_decode_assert.sv
dv/tb_inst_decode.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_inst_decode
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
